//--- laser_link.f
+incdir+hdl
hdl/laser_frame_pkg.sv
hdl/laser_host_pkg.sv
hdl/laser_pair_if.sv
hdl/sync_fifo.sv
hdl/laser_transmitter.sv
hdl/laser_receiver.sv
hdl/ftdi_bridge.sv
hdl/laser_link.sv
testbench/laser_link_props.sv
testbench/laser_link_tb.sv

//--- testbench/laser_link_stim.txt
# op b1 b2 in hex: L loopback pair, G frame with glitches, B frame with a bad stop bit
# T n holds txe high for n cycles, E opens an enable gap for the next pair
L 3c a5
L 00 ff
G 5a c3
L 81 7e
B 12 34
L 12 34
T 300
L 01 02
L 10 20
L 40 80
G e7 18
E
L 96 69
L de ad
B ff 00
L be ef

//--- testbench/laser_link_tb.sv
`timescale 1ns/1ps
`include "laser_link_defines.svh"

module laser_link_tb;
    import laser_host_pkg::*;
    import laser_frame_pkg::*;

    localparam int FRAME_CYCLES = `LASER_BIT_TICKS * `LASER_FRAME_BITS;
    localparam int TIMEOUT = 2000;
    localparam int GLITCH_TICK = 4;
    localparam int GAP_CYCLES = 40;
    localparam string STIM_PATH = "testbench/laser_link_stim.txt";

    logic clock;
    logic reset;
    logic en;
    logic rxf;
    logic txe;
    logic laser1_rx;
    logic laser2_rx;
    host_byte_t adbus_in;
    logic ftdi_rd;
    logic ftdi_wr;
    logic adbus_tri;
    host_byte_t adbus_out;
    logic [1:0] laser1_tx;
    logic [1:0] laser2_tx;
    logic tx_done;

    // Line mux selects loopback unless a frame is being injected
    logic inject;
    logic inj1;
    logic inj2;

    host_byte_t serve_q[$];
    host_byte_t expect_q[$];
    logic [1:0] line_q[$];
    logic rd_taken;
    logic txe_prev;
    int txe_left;
    int en_left;
    logic meas_active;
    int meas_count;
    int done_count;
    int pairs_sent;

    laser_link dut (
        .clock(clock),
        .reset(reset),
        .en(en),
        .rxf(rxf),
        .txe(txe),
        .laser1_rx(laser1_rx),
        .laser2_rx(laser2_rx),
        .adbus_in(adbus_in),
        .ftdi_rd(ftdi_rd),
        .ftdi_wr(ftdi_wr),
        .adbus_tri(adbus_tri),
        .adbus_out(adbus_out),
        .laser1_tx(laser1_tx),
        .laser2_tx(laser2_tx),
        .tx_done(tx_done)
    );

    bind laser_link laser_link_props props (
        .clock(clock),
        .reset(reset),
        .ftdi_rd(ftdi_rd),
        .ftdi_wr(ftdi_wr),
        .adbus_tri(adbus_tri),
        .laser1_tx(laser1_tx),
        .laser2_tx(laser2_tx),
        .load(pair_if.load)
    );

    assign laser1_rx = inject ? inj1 : laser1_tx[1];
    assign laser2_rx = inject ? inj2 : laser2_tx[1];

    always #5 clock = ~clock;

    task automatic stop_on_error(input string what);
        $display("%s", what);
        $display("RESULT: FAIL");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_byte(input string name, input host_byte_t got, input host_byte_t exp);
        if (got !== exp) begin
            stop_on_error($sformatf("error %s got 0x%02h expected 0x%02h", name, got, exp));
        end
    endtask

    task automatic check_pulse(input string name, input int got, input int exp);
        if (got != exp) begin
            stop_on_error($sformatf("error %s got 0x%0h expected 0x%0h", name, got, exp));
        end
    endtask

    task automatic check_lane(input string name, input logic [1:0] got, input logic [1:0] exp);
        if (got !== exp) begin
            stop_on_error($sformatf("error %s got 0x%0h expected 0x%0h", name, got, exp));
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            stop_on_error($sformatf("error %s got 0x%0h expected 0x%0h", name, got, exp));
        end
    endtask

    // Start bit 1, data LSB first, then the stop bit
    function automatic logic frame_bit(input laser_byte_t data, input int idx, input logic stop);
        if (idx == 0) begin
            return 1'b1;
        end
        if (idx == `LASER_FRAME_BITS - 1) begin
            return stop;
        end
        return data[idx - 1];
    endfunction

    // Host model and output checks run once per cycle
    task automatic watch_outputs();
        if (dut.props.fail_count != 0) begin
            stop_on_error("a bound assertion on the host port or laser lines failed");
        end
        if (!ftdi_rd) begin
            if (serve_q.size() == 0) begin
                stop_on_error("read strobe while the host had no byte to offer");
            end
            rd_taken = 1'b1;
        end
        if (!ftdi_wr) begin
            if (txe_prev) begin
                stop_on_error("write strobe while txe was high");
            end
            if (expect_q.size() == 0) begin
                stop_on_error("host write with no pair expected");
            end
            check_flag("adbus_tri", adbus_tri, 1'b1);
            check_byte("adbus_out", adbus_out, expect_q.pop_front());
        end
        if (!en) begin
            check_lane("laser1_tx", laser1_tx, 2'b00);
            check_lane("laser2_tx", laser2_tx, 2'b00);
        end else begin
            check_flag("laser1_tx[0]", laser1_tx[0], 1'b1);
            check_flag("laser2_tx[0]", laser2_tx[0], 1'b1);
        end
        // Frame time runs only while enable is high
        if (meas_active) begin
            if (en) begin
                meas_count++;
            end else begin
                meas_count = 0;
            end
        end
        if (tx_done) begin
            if (!meas_active) begin
                stop_on_error("tx_done pulse without a loaded pair");
            end
            check_pulse("load to tx_done cycles", meas_count, FRAME_CYCLES);
            meas_active = 1'b0;
            done_count++;
        end
        if (dut.pair_if.load) begin
            meas_active = 1'b1;
            meas_count = 0;
        end
    endtask

    task automatic step();
        @(negedge clock);
        txe_prev = txe;
        if (rd_taken) begin
            void'(serve_q.pop_front());
            rd_taken = 1'b0;
        end
        rxf = (serve_q.size() == 0);
        if (serve_q.size() != 0) begin
            adbus_in = serve_q[0];
        end
        txe = (txe_left > 0);
        if (txe_left > 0) begin
            txe_left--;
        end
        en = (en_left == 0);
        if (en_left > 0) begin
            en_left--;
        end
        if (line_q.size() != 0) begin
            {inj1, inj2} = line_q.pop_front();
            inject = 1'b1;
        end else begin
            inj1 = 1'b0;
            inj2 = 1'b0;
            inject = 1'b0;
        end
        #1;
        watch_outputs();
    endtask

    // Steps until every byte is served and written back and the transmitter is idle
    task automatic drain();
        int waited;
        waited = 0;
        while (serve_q.size() != 0 || expect_q.size() != 0 || meas_active) begin
            step();
            waited++;
            if (waited > TIMEOUT) begin
                stop_on_error("timeout waiting for pending pairs to reach the host");
            end
        end
    endtask

    task automatic send_loopback(input host_byte_t b1, input host_byte_t b2);
        int waited;
        serve_q.push_back(b1);
        serve_q.push_back(b2);
        expect_q.push_back(b1);
        expect_q.push_back(b2);
        pairs_sent++;
        waited = 0;
        while (done_count != pairs_sent) begin
            step();
            waited++;
            if (waited > TIMEOUT) begin
                stop_on_error("timeout waiting for tx_done");
            end
        end
    endtask

    task automatic send_injected(input host_byte_t b1, input host_byte_t b2,
                                 input logic glitch, input logic bad_stop);
        int waited;
        logic v1;
        logic v2;
        drain();
        for (int i = 0; i < FRAME_CYCLES; i++) begin
            v1 = frame_bit(b1, i / `LASER_BIT_TICKS, bad_stop);
            v2 = frame_bit(b2, i / `LASER_BIT_TICKS, bad_stop);
            // One inverted sample in the middle of the vote window
            if (glitch && (i % `LASER_BIT_TICKS == GLITCH_TICK)) begin
                v1 = ~v1;
                v2 = ~v2;
            end
            line_q.push_back({v1, v2});
        end
        if (!bad_stop) begin
            expect_q.push_back(b1);
            expect_q.push_back(b2);
        end
        waited = 0;
        while (line_q.size() != 0) begin
            step();
            waited++;
            if (waited > TIMEOUT) begin
                stop_on_error("timeout while injecting a frame");
            end
        end
        // Synchronizer and last bit clear before the line is reused
        repeat (`LASER_BIT_TICKS) step();
    endtask

    initial begin
        int fd;
        int code;
        int n;
        logic [7:0] op;
        host_byte_t b1;
        host_byte_t b2;
        string line;
        clock = 1'b0;
        reset = 1'b1;
        en = 1'b1;
        rxf = 1'b1;
        txe = 1'b0;
        adbus_in = '0;
        inject = 1'b0;
        inj1 = 1'b0;
        inj2 = 1'b0;
        rd_taken = 1'b0;
        txe_prev = 1'b0;
        txe_left = 0;
        en_left = 0;
        meas_active = 1'b0;
        meas_count = 0;
        done_count = 0;
        pairs_sent = 0;
        repeat (4) @(negedge clock);
        reset = 1'b0;
        #1;
        check_flag("ftdi_rd", ftdi_rd, 1'b1);
        check_flag("ftdi_wr", ftdi_wr, 1'b1);
        check_flag("adbus_tri", adbus_tri, 1'b0);
        check_flag("laser1_tx[1]", laser1_tx[1], 1'b0);
        check_flag("laser2_tx[1]", laser2_tx[1], 1'b0);
        check_flag("tx_done", tx_done, 1'b0);
        check_flag("load", dut.pair_if.load, 1'b0);

        fd = $fopen(STIM_PATH, "r");
        if (fd == 0) begin
            stop_on_error("could not open the stimulus file");
        end
        code = $fscanf(fd, " %c", op);
        while (code == 1) begin
            case (op)
                "#": code = $fgets(line, fd);
                "L", "G", "B": begin
                    code = $fscanf(fd, "%h %h", b1, b2);
                    if (code != 2) begin
                        stop_on_error("stimulus line is missing its two bytes");
                    end
                    if (op == "L") begin
                        send_loopback(b1, b2);
                    end else begin
                        send_injected(b1, b2, op == "G", op == "B");
                    end
                end
                "T": begin
                    code = $fscanf(fd, "%d", n);
                    if (code != 1) begin
                        stop_on_error("stimulus T line is missing its cycle count");
                    end
                    drain();
                    txe_left = n;
                end
                "E": begin
                    drain();
                    en_left = GAP_CYCLES;
                end
                default: stop_on_error($sformatf("unknown opcode %c in the stimulus file", op));
            endcase
            code = $fscanf(fd, " %c", op);
        end
        $fclose(fd);

        drain();
        // Any stray write shows up on the quiet line
        repeat (FRAME_CYCLES) step();
        check_pulse("tx_done pulses", done_count, pairs_sent);
        if (dut.props.fail_count == 0) begin
            $display("RESULT: PASS");
            $finish;
        end else begin
            stop_on_error("a bound assertion on the host port or laser lines failed");
        end
    end

endmodule

//--- testbench/laser_link_props.sv
`timescale 1ns/1ps

module laser_link_props (
    input logic       clock,
    input logic       reset,
    input logic       ftdi_rd,
    input logic       ftdi_wr,
    input logic       adbus_tri,
    input logic [1:0] laser1_tx,
    input logic [1:0] laser2_tx,
    input logic       load
);
    int fail_count = 0;
    logic loaded;

    // Set by the first pair handed to the transmitter
    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            loaded <= 1'b0;
        end else if (load) begin
            loaded <= 1'b1;
        end
    end

    rd_wr_apart: assert property (@(posedge clock) disable iff (reset) ftdi_rd || ftdi_wr)
        else begin
            fail_count++;
            $error("ftdi_rd and ftdi_wr low together");
        end

    tri_with_write: assert property (@(posedge clock) disable iff (reset)
        adbus_tri |-> !ftdi_wr)
        else begin
            fail_count++;
            $error("adbus_tri high outside a write strobe");
        end

    rd_single_cycle: assert property (@(posedge clock) disable iff (reset)
        !ftdi_rd |=> ftdi_rd)
        else begin
            fail_count++;
            $error("ftdi_rd low on two cycles in a row");
        end

    dark_until_load: assert property (@(posedge clock) disable iff (reset)
        !loaded |-> !laser1_tx[1] && !laser2_tx[1])
        else begin
            fail_count++;
            $error("laser data bit high before the first load");
        end

endmodule

//--- hdl/laser_link.sv
`timescale 1ns/1ps
`include "laser_link_defines.svh"

module laser_link (
    input  logic                       clock,
    input  logic                       reset,
    input  logic                       en,
    input  logic                       rxf,
    input  logic                       txe,
    input  logic                       laser1_rx,
    input  logic                       laser2_rx,
    input  laser_host_pkg::host_byte_t adbus_in,
    output logic                       ftdi_rd,
    output logic                       ftdi_wr,
    output logic                       adbus_tri,
    output laser_host_pkg::host_byte_t adbus_out,
    output logic [1:0]                 laser1_tx,
    output logic [1:0]                 laser2_tx,
    output logic                       tx_done
);
    import laser_frame_pkg::*;

    lane_pair_t rx_pair;
    logic rx_pair_valid;

    laser_pair_if pair_if ();

    ftdi_bridge bridge (
        .clock(clock),
        .reset(reset),
        .rxf(rxf),
        .txe(txe),
        .adbus_in(adbus_in),
        .ftdi_rd(ftdi_rd),
        .ftdi_wr(ftdi_wr),
        .adbus_tri(adbus_tri),
        .adbus_out(adbus_out),
        .rx_pair(rx_pair),
        .rx_pair_valid(rx_pair_valid),
        .pair_port(pair_if.bridge)
    );

    laser_transmitter transmitter (
        .clock(clock),
        .reset(reset),
        .en(en),
        .pair_port(pair_if.transmitter),
        .laser1_tx(laser1_tx),
        .laser2_tx(laser2_tx)
    );

    laser_receiver receiver (
        .clock(clock),
        .reset(reset),
        .laser1_rx(laser1_rx),
        .laser2_rx(laser2_rx),
        .pair(rx_pair),
        .pair_valid(rx_pair_valid)
    );

    assign tx_done = pair_if.done;

endmodule

//--- hdl/ftdi_bridge.sv
`timescale 1ns/1ps
`include "laser_link_defines.svh"

module ftdi_bridge (
    input  logic                        clock,
    input  logic                        reset,
    input  logic                        rxf,
    input  logic                        txe,
    input  laser_host_pkg::host_byte_t  adbus_in,
    output logic                        ftdi_rd,
    output logic                        ftdi_wr,
    output logic                        adbus_tri,
    output laser_host_pkg::host_byte_t  adbus_out,
    input  laser_frame_pkg::lane_pair_t rx_pair,
    input  logic                        rx_pair_valid,
    laser_pair_if.bridge                pair_port
);
    import laser_host_pkg::*;
    import laser_frame_pkg::*;

    bridge_state_t state;
    host_byte_t host_head;
    host_byte_t first_byte;
    logic host_push;
    logic host_pop;
    logic host_empty;
    logic host_full;
    lane_pair_t rx_head;
    logic rx_push;
    logic rx_pop;
    logic rx_empty;
    logic rx_full;
    logic have_first;

    sync_fifo #(
        .DEPTH(`HOST_FIFO_DEPTH),
        .payload_t(host_byte_t)
    ) host_fifo (
        .clock(clock),
        .reset(reset),
        .push(host_push),
        .din(adbus_in),
        .pop(host_pop),
        .head(host_head),
        .empty(host_empty),
        .full(host_full)
    );

    // Pairs arriving while the queue is full are lost
    assign rx_push = rx_pair_valid & ~rx_full;

    sync_fifo #(
        .DEPTH(`PAIR_FIFO_DEPTH),
        .payload_t(lane_pair_t)
    ) rx_fifo (
        .clock(clock),
        .reset(reset),
        .push(rx_push),
        .din(rx_pair),
        .pop(rx_pop),
        .head(rx_head),
        .empty(rx_empty),
        .full(rx_full)
    );

    // Pairing, the first byte waits here for its partner
    assign pair_port.pair = '{lane1: first_byte, lane2: host_head};
    assign pair_port.load = have_first & ~host_empty & ~pair_port.busy;
    assign host_pop = (~have_first & ~host_empty) | pair_port.load;

    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            have_first <= 1'b0;
        end else if (pair_port.load) begin
            have_first <= 1'b0;
        end else if (host_pop) begin
            have_first <= 1'b1;
        end
    end

    always_ff @(posedge clock) begin
        if (!have_first && !host_empty) begin
            first_byte <= host_head;
        end
    end

    // Strobes are registered, so each state below sees its own strobe level
    assign host_push = (state == BR_READ);
    assign rx_pop = (state == BR_WRITE2) && !ftdi_wr;

    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            state <= BR_IDLE;
            ftdi_rd <= 1'b1;
            ftdi_wr <= 1'b1;
            adbus_tri <= 1'b0;
        end else begin
            case (state)
                BR_IDLE: begin
                    if (!txe && !rx_empty) begin
                        state <= BR_WRITE1;
                        ftdi_wr <= 1'b0;
                        adbus_tri <= 1'b1;
                    end else if (!rxf && !host_full) begin
                        state <= BR_READ;
                        ftdi_rd <= 1'b0;
                    end
                end
                BR_READ: begin
                    ftdi_rd <= 1'b1;
                    state <= BR_IDLE;
                end
                BR_WRITE1: begin
                    ftdi_wr <= 1'b1;
                    adbus_tri <= 1'b0;
                    state <= BR_WRITE2;
                end
                BR_WRITE2: begin
                    if (!ftdi_wr) begin
                        ftdi_wr <= 1'b1;
                        adbus_tri <= 1'b0;
                        state <= BR_IDLE;
                    end else if (!txe) begin
                        ftdi_wr <= 1'b0;
                        adbus_tri <= 1'b1;
                    end
                end
                default: state <= BR_IDLE;
            endcase
        end
    end

    // Lane 1 goes out first, lane 2 on the second strobe
    always_ff @(posedge clock) begin
        if (state == BR_IDLE) begin
            adbus_out <= rx_head.lane1;
        end else if (state == BR_WRITE2 && ftdi_wr) begin
            adbus_out <= rx_head.lane2;
        end
    end

endmodule

//--- hdl/laser_receiver.sv
`timescale 1ns/1ps
`include "laser_link_defines.svh"

module laser_receiver (
    input  logic                       clock,
    input  logic                       reset,
    input  logic                       laser1_rx,
    input  logic                       laser2_rx,
    output laser_frame_pkg::lane_pair_t pair,
    output logic                       pair_valid
);
    import laser_frame_pkg::*;

    localparam int TICK_W = $clog2(`LASER_BIT_TICKS);
    localparam int BIT_W = $clog2(`LASER_FRAME_BITS);
    localparam int MSB = `LASER_FRAME_BITS - 1;
    localparam logic [TICK_W-1:0] LAST_TICK = TICK_W'(`LASER_BIT_TICKS - 1);
    localparam logic [TICK_W-1:0] VOTE_FIRST = TICK_W'(`LASER_VOTE_FIRST);
    localparam logic [TICK_W-1:0] VOTE_LAST = TICK_W'(`LASER_VOTE_LAST);
    localparam logic [BIT_W-1:0] LAST_BIT = BIT_W'(`LASER_FRAME_BITS - 1);

    rx_state_t state;
    logic [1:0] sync1;
    logic [1:0] sync2;
    logic line1;
    logic line2;
    logic [TICK_W-1:0] tick;
    logic [BIT_W-1:0] bit_idx;
    logic [1:0] vote1;
    logic [1:0] vote2;
    logic in_vote;
    logic bit_end;
    logic frame_end;
    logic frame_ok;
    logic [MSB:0] shift1;
    logic [MSB:0] shift2;
    logic [MSB:0] next1;
    logic [MSB:0] next2;
    laser_byte_t data1;
    laser_byte_t data2;

    // Two-flop synchronizers on the incoming light
    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            sync1 <= '0;
            sync2 <= '0;
        end else begin
            sync1 <= {sync1[0], laser1_rx};
            sync2 <= {sync2[0], laser2_rx};
        end
    end

    assign line1 = sync1[1];
    assign line2 = sync2[1];

    assign in_vote = (tick >= VOTE_FIRST) && (tick <= VOTE_LAST);
    assign bit_end = (state == RX_RECEIVE) && (tick == LAST_TICK);
    assign frame_end = bit_end && (bit_idx == LAST_BIT);

    // Two or three high samples make a 1, newest bit enters at the top
    assign next1 = {vote1[1], shift1[MSB:1]};
    assign next2 = {vote2[1], shift2[MSB:1]};

    // Start bit must be 1 and stop bit 0 on both lanes
    assign frame_ok = next1[0] & next2[0] & ~next1[MSB] & ~next2[MSB];
    assign data1 = next1[MSB-1:1];
    assign data2 = next2[MSB-1:1];

    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            state <= RX_IDLE;
            tick <= '0;
            bit_idx <= '0;
            vote1 <= '0;
            vote2 <= '0;
            pair_valid <= 1'b0;
        end else begin
            pair_valid <= 1'b0;
            case (state)
                RX_IDLE: begin
                    vote1 <= '0;
                    vote2 <= '0;
                    bit_idx <= '0;
                    // First cycle with light is tick 0 of the start bit
                    if (line1 || line2) begin
                        state <= RX_RECEIVE;
                        tick <= TICK_W'(1);
                    end else begin
                        tick <= '0;
                    end
                end
                RX_RECEIVE: begin
                    if (in_vote) begin
                        vote1 <= vote1 + {1'b0, line1};
                        vote2 <= vote2 + {1'b0, line2};
                    end
                    if (tick == LAST_TICK) begin
                        tick <= '0;
                        vote1 <= '0;
                        vote2 <= '0;
                        if (bit_idx == LAST_BIT) begin
                            state <= RX_IDLE;
                            bit_idx <= '0;
                            pair_valid <= frame_ok;
                        end else begin
                            bit_idx <= bit_idx + 1'b1;
                        end
                    end else begin
                        tick <= tick + 1'b1;
                    end
                end
                default: state <= RX_IDLE;
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (bit_end) begin
            shift1 <= next1;
            shift2 <= next2;
        end
        if (frame_end && frame_ok) begin
            pair <= '{lane1: data1, lane2: data2};
        end
    end

endmodule

//--- hdl/laser_transmitter.sv
`timescale 1ns/1ps
`include "laser_link_defines.svh"

module laser_transmitter (
    input  logic              clock,
    input  logic              reset,
    input  logic              en,
    laser_pair_if.transmitter pair_port,
    output logic [1:0]        laser1_tx,
    output logic [1:0]        laser2_tx
);
    import laser_frame_pkg::*;

    localparam int TICK_W = $clog2(`LASER_BIT_TICKS);
    localparam int BIT_W = $clog2(`LASER_FRAME_BITS);
    localparam logic [TICK_W-1:0] LAST_TICK = TICK_W'(`LASER_BIT_TICKS - 1);
    localparam logic [BIT_W-1:0] LAST_BIT = BIT_W'(`LASER_FRAME_BITS - 1);

    lane_pair_t pair_q;
    logic [TICK_W-1:0] tick;
    logic [BIT_W-1:0] bit_idx;
    logic [`LASER_FRAME_BITS-1:0] frame1;
    logic [`LASER_FRAME_BITS-1:0] frame2;
    logic sending;

    always_ff @(posedge clock) begin
        if (pair_port.load) begin
            pair_q <= pair_port.pair;
        end
    end

    // Stop bit on top, start bit at index 0, data LSB first
    assign frame1 = {1'b0, pair_q.lane1, 1'b1};
    assign frame2 = {1'b0, pair_q.lane2, 1'b1};

    assign sending = pair_port.busy & en;

    // One counter pair drives both lanes so they stay in step
    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            pair_port.busy <= 1'b0;
            tick <= '0;
            bit_idx <= '0;
        end else if (pair_port.load) begin
            pair_port.busy <= 1'b1;
            tick <= '0;
            bit_idx <= '0;
        end else if (!en) begin
            // Frame restarts from its start bit once enable is back
            tick <= '0;
            bit_idx <= '0;
        end else if (pair_port.busy) begin
            if (tick == LAST_TICK) begin
                tick <= '0;
                if (bit_idx == LAST_BIT) begin
                    bit_idx <= '0;
                    pair_port.busy <= 1'b0;
                end else begin
                    bit_idx <= bit_idx + 1'b1;
                end
            end else begin
                tick <= tick + 1'b1;
            end
        end
    end

    // Last clock of the stop bit
    assign pair_port.done = sending && (tick == LAST_TICK) && (bit_idx == LAST_BIT);

    // Bit 0 is the transmit enable, bit 1 the light itself
    assign laser1_tx = {sending & frame1[bit_idx], en};
    assign laser2_tx = {sending & frame2[bit_idx], en};

endmodule

//--- hdl/sync_fifo.sv
`timescale 1ns/1ps
`include "laser_link_defines.svh"

module sync_fifo #(
    parameter int DEPTH = `HOST_FIFO_DEPTH,
    parameter type payload_t = logic [7:0]
) (
    input  logic     clock,
    input  logic     reset,
    input  logic     push,
    input  payload_t din,
    input  logic     pop,
    output payload_t head,
    output logic     empty,
    output logic     full
);
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);
    localparam logic [PTR_W-1:0] LAST_SLOT = PTR_W'(DEPTH - 1);

    payload_t mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic do_push;
    logic do_pop;

    assign do_push = push & ~full;
    assign do_pop = pop & ~empty;
    assign empty = (count == '0);
    assign full = (count == CNT_W'(DEPTH));

    // Oldest entry shown without waiting for pop
    assign head = mem[rd_ptr];

    always_ff @(posedge clock) begin
        if (do_push) begin
            mem[wr_ptr] <= din;
        end
    end

    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == LAST_SLOT) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == LAST_SLOT) ? '0 : rd_ptr + 1'b1;
            end
            if (do_push && !do_pop) begin
                count <= count + 1'b1;
            end else if (do_pop && !do_push) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

//--- hdl/laser_pair_if.sv
`timescale 1ns/1ps

interface laser_pair_if;
    import laser_frame_pkg::*;

    lane_pair_t pair;
    logic load;
    logic busy;
    logic done;

    // Load is a single-cycle strobe, only raised while busy is low
    modport bridge (
        output pair,
        output load,
        input  busy,
        input  done
    );

    modport transmitter (
        input  pair,
        input  load,
        output busy,
        output done
    );

endinterface

//--- hdl/laser_host_pkg.sv
package laser_host_pkg;

    // Byte as seen on adbus
    typedef logic [7:0] host_byte_t;

    // Host port sequencer
    typedef enum logic [1:0] {
        BR_IDLE,
        BR_READ,
        BR_WRITE1,
        BR_WRITE2
    } bridge_state_t;

endpackage

//--- hdl/laser_frame_pkg.sv
package laser_frame_pkg;

    // One lane's data byte
    typedef logic [7:0] laser_byte_t;

    // Lane 1 always carries the earlier host byte
    typedef struct packed {
        laser_byte_t lane1;
        laser_byte_t lane2;
    } lane_pair_t;

    // Receiver control
    typedef enum logic {
        RX_IDLE,
        RX_RECEIVE
    } rx_state_t;

endpackage

//--- hdl/laser_link_defines.svh
`ifndef LASER_LINK_DEFINES_SVH
`define LASER_LINK_DEFINES_SVH

// Clocks spent on each line bit
`define LASER_BIT_TICKS 8

// Receiver samples each bit at ticks 3, 4 and 5
`define LASER_VOTE_FIRST 3
`define LASER_VOTE_LAST 5

// Start bit, eight data bits, stop bit
`define LASER_FRAME_BITS 10

// Bytes waiting to be paired
`define HOST_FIFO_DEPTH 8

// Received pairs waiting for the host
`define PAIR_FIFO_DEPTH 4

`endif
